// ==== rtl/frontPkg.sv ====
package frontPkg;

    localparam int unsigned memWords = 64;
    localparam int unsigned memAddrW = $clog2(memWords);
    localparam logic [63:0] resetPc  = 64'h0;
    localparam logic [63:0] pcLimit  = 64'(memWords * 4); // first pc past the memory

    // exact system words
    localparam logic [31:0] instrEcall  = 32'h0000_0073;
    localparam logic [31:0] instrEbreak = 32'h0010_0073;
    localparam logic [31:0] instrMret   = 32'h3020_0073;

    typedef enum logic [4:0] {
        opLoad    = 5'b00000,
        opOpImm   = 5'b00100,
        opAuipc   = 5'b00101,
        opOpImm32 = 5'b00110,
        opStore   = 5'b01000,
        opOp      = 5'b01100,
        opLui     = 5'b01101,
        opOp32    = 5'b01110,
        opBranch  = 5'b11000,
        opJalr    = 5'b11001,
        opJal     = 5'b11011,
        opSystem  = 5'b11100
    } majorOp;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immJ = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immU = 3'b101
    } immKind;

    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,
        brGe   = 3'b111
    } branchKind;

    // low 3 bits follow funct3, top bit selects sub/sra
    typedef enum logic [3:0] {
        aluAdd   = 4'b0000,
        aluSll   = 4'b0001,
        aluSlt   = 4'b0010,
        aluSltu  = 4'b0011,
        aluXor   = 4'b0100,
        aluSrl   = 4'b0101,
        aluOr    = 4'b0110,
        aluAnd   = 4'b0111,
        aluSub   = 4'b1000,
        aluSra   = 4'b1101,
        aluPassB = 4'b1111
    } aluOp;

    typedef struct packed {
        logic                we;
        logic                re;
        logic [memAddrW-1:0] addr;
        logic [31:0]         wdata;
    } memReq;

    typedef struct packed {
        logic       regWr;
        logic       memRd;
        logic       memWr;
        logic [2:0] memOp;
        logic       aluASrc;
        logic [1:0] aluBSrc;
        aluOp       aluCtl;
        logic       word32;
        branchKind  branch;
        logic       csr;
        logic       isMul;
        logic       isDiv;
        logic       isAlu;
    } decodeCtrl;

    typedef struct packed {
        logic        valid;
        logic [63:0] pc;
        logic [31:0] imm;
        logic [4:0]  rd;
        decodeCtrl   ctrl;
        logic [11:0] csrAddr;
        logic        ecall;
        logic        mret;
        logic        done;
        logic        error;
    } decodeOut;

endpackage

// ==== rtl/instrMem.sv ====
`timescale 1ns/1ps

module instrMem (
    input  logic            clk,
    input  frontPkg::memReq req,
    output logic [31:0]     rdata
);
    import frontPkg::*;

    logic [31:0] mem [memWords];

    // write wins, read data held otherwise
    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end else if (req.re) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

// ==== rtl/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          loadEn,
    input  logic [frontPkg::memAddrW-1:0] loadAddr,
    input  logic [31:0]                   loadData,
    input  logic                          fetchRd,
    input  logic [frontPkg::memAddrW-1:0] fetchAddr,
    output logic                          fetchGnt,
    output frontPkg::memReq               memPort
);

    assign fetchGnt = !loadEn;

    always_comb begin
        memPort.we    = loadEn;
        memPort.re    = fetchRd && !loadEn;
        memPort.addr  = loadEn ? loadAddr : fetchAddr;
        memPort.wdata = loadData;
    end

endmodule

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          block,
    input  logic                          redirect,
    input  logic [63:0]                   redirectPc,
    input  logic                          gnt,
    output logic                          rdReq,
    output logic [frontPkg::memAddrW-1:0] rdAddr,
    output logic                          issue,
    output logic [63:0]                   issuePc,
    output logic                          fault
);
    import frontPkg::*;

    logic [63:0] pc;
    logic        running; // first cycle out of reset issues nothing
    logic        inRange;
    logic        go;

    assign inRange = (pc < pcLimit) && (pc[1:0] == 2'b00);
    assign go      = running && !block && !redirect;

    assign rdReq   = go && inRange;
    assign rdAddr  = pc[memAddrW+1:2];
    assign issue   = go && gnt;
    assign issuePc = pc;
    assign fault   = !inRange;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (issue && inRange) begin
            pc <= pc + 64'd4;
        end
    end

endmodule

// ==== rtl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
    input  logic [31:0]         instr,
    output frontPkg::immKind    kind,
    output frontPkg::decodeCtrl ctrl,
    output logic                encErr
);
    import frontPkg::*;

    majorOp     major;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       mulDiv;
    logic       err;

    assign major  = majorOp'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign mulDiv = (major == opOp || major == opOp32) && funct7 == 7'b0000001;

    always_comb begin
        kind         = immI;
        ctrl.regWr   = major != opBranch && major != opStore;
        ctrl.memRd   = major == opLoad;
        ctrl.memWr   = major == opStore;
        ctrl.memOp   = funct3;
        ctrl.aluASrc = major == opAuipc || major == opJal || major == opJalr; // pc into a
        ctrl.aluBSrc = 2'd2; // imm into b
        ctrl.aluCtl  = aluAdd;
        ctrl.word32  = major == opOpImm32 || major == opOp32;
        ctrl.branch  = brNone;
        ctrl.csr     = major == opSystem;
        ctrl.isMul   = mulDiv && !funct3[2];
        ctrl.isDiv   = mulDiv && funct3[2];
        ctrl.isAlu   = !mulDiv;
        err          = 1'b0;
        case (major)
            opSystem: begin
                ctrl.aluBSrc = 2'd3; // csr value
                ctrl.aluCtl  = aluPassB;
                err          = funct3 == 3'b100;
            end
            opLui: begin
                kind        = immU;
                ctrl.aluCtl = aluPassB;
            end
            opAuipc: begin
                kind = immU;
            end
            opJal: begin
                kind         = immJ;
                ctrl.aluBSrc = 2'd1; // constant 4 for link
                ctrl.branch  = brJal;
            end
            opJalr: begin
                ctrl.aluBSrc = 2'd1;
                ctrl.branch  = brJalr;
                err          = funct3 != 3'b000;
            end
            opBranch: begin
                kind         = immB;
                ctrl.aluBSrc = 2'd0;
                ctrl.aluCtl  = funct3[2:1] == 2'b11 ? aluSltu : aluSlt;
                case (funct3)
                    3'b000: ctrl.branch = brEq;
                    3'b001: ctrl.branch = brNe;
                    3'b100, 3'b110: ctrl.branch = brLt;
                    3'b101, 3'b111: ctrl.branch = brGe;
                    default: err = 1'b1;
                endcase
            end
            opLoad: begin
                err = funct3 == 3'b111;
            end
            opStore: begin
                kind = immS;
                err  = funct3[2];
            end
            opOpImm: begin
                ctrl.aluCtl = aluOp'({funct7[5] && funct3 == 3'b101, funct3});
                // six-bit shamt leaves funct7[0] free
                err = (funct3 == 3'b001 && funct7[6:1] != 6'b000000) ||
                      (funct3 == 3'b101 && funct7[6:1] != 6'b000000 &&
                       funct7[6:1] != 6'b010000);
            end
            opOpImm32: begin
                ctrl.aluCtl = aluOp'({funct7[5] && funct3 == 3'b101, funct3});
                err = funct3 != 3'b000 &&
                      (funct3 != 3'b001 || funct7 != 7'b0000000) &&
                      (funct3 != 3'b101 || (funct7 != 7'b0000000 && funct7 != 7'b0100000));
            end
            opOp: begin
                ctrl.aluBSrc = 2'd0;
                ctrl.aluCtl  = aluOp'({funct7[5], funct3});
                case (funct7)
                    7'b0000000, 7'b0000001: err = 1'b0;
                    7'b0100000: err = funct3 != 3'b000 && funct3 != 3'b101;
                    default: err = 1'b1;
                endcase
            end
            opOp32: begin
                ctrl.aluBSrc = 2'd0;
                ctrl.aluCtl  = aluOp'({funct7[5], funct3});
                case (funct7)
                    7'b0000000: err = !(funct3 == 3'b000 || funct3 == 3'b001 ||
                                        funct3 == 3'b101);
                    7'b0100000: err = funct3 != 3'b000 && funct3 != 3'b101;
                    7'b0000001: err = funct3 == 3'b001 || funct3 == 3'b010 ||
                                      funct3 == 3'b011; // no mulh forms in w
                    default: err = 1'b1;
                endcase
            end
            default: begin
                ctrl.aluBSrc = 2'd0;
                err          = 1'b1;
            end
        endcase
    end

    assign encErr = err || instr[1:0] != 2'b11;

endmodule

// ==== rtl/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [31:0]      instr,
    input  frontPkg::immKind kind,
    output logic [31:0]      imm
);
    import frontPkg::*;

    logic isU;
    logic isJ;
    logic isS;
    logic isB;
    logic sign;

    assign isU  = kind == immU;
    assign isJ  = kind == immJ;
    assign isS  = kind == immS;
    assign isB  = kind == immB;
    assign sign = instr[31];

    assign imm[31]    = sign;
    assign imm[30:20] = isU ? instr[30:20] : {11{sign}};
    assign imm[19:12] = (isU || isJ) ? instr[19:12] : {8{sign}};
    assign imm[11]    = isU ? 1'b0 :
                        isB ? instr[7] :
                        isJ ? instr[20] : sign;
    assign imm[10:5]  = isU ? 6'b0 : instr[30:25];
    assign imm[4:1]   = isU ? 4'b0 :
                        (isS || isB) ? instr[11:8] : instr[24:21];
    assign imm[0]     = (isU || isJ || isB) ? 1'b0 :
                        isS ? instr[7] : instr[20];

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
    input  logic               clk,
    input  logic               arstN,
    input  logic               block,
    input  logic               issue,
    input  logic [63:0]        issuePc,
    input  logic               fault,
    input  logic [31:0]        instr,
    input  logic               csrIllegal,
    output frontPkg::decodeOut result
);
    import frontPkg::*;

    logic        validQ;
    logic        faultQ;
    logic [63:0] pcQ;
    immKind      kind;
    decodeCtrl   ctrl;
    logic        encErr;
    logic [31:0] imm;
    logic        isEcall;
    logic        isEbreak;
    logic        isMret;
    logic        badSystem;
    logic        badCsr;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
            faultQ <= 1'b0;
        end else if (!block) begin
            validQ <= issue;
            faultQ <= fault;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            pcQ <= issuePc;
        end
    end

    instrDecoder u_decoder (
        .instr  (instr),
        .kind   (kind),
        .ctrl   (ctrl),
        .encErr (encErr)
    );

    immGen u_immGen (
        .instr (instr),
        .kind  (kind),
        .imm   (imm)
    );

    assign isEcall   = instr == instrEcall;
    assign isEbreak  = instr == instrEbreak;
    assign isMret    = instr == instrMret;
    // funct3 zero in system space is only legal as the three exact words
    assign badSystem = ctrl.csr && instr[14:12] == 3'b000 && !(isEcall || isEbreak || isMret);
    assign badCsr    = ctrl.csr && instr[14:12] != 3'b000 && csrIllegal;

    always_comb begin
        result.valid   = validQ;
        result.pc      = pcQ;
        result.imm     = imm;
        result.rd      = instr[11:7];
        result.ctrl    = ctrl;
        result.csrAddr = instr[31:20];
        result.ecall   = isEcall;
        result.mret    = isMret;
        result.done    = isEbreak; // ebreak ends the program
        result.error   = encErr || faultQ || badSystem || badCsr;
    end

endmodule

// ==== rtl/frontEnd.sv ====
`timescale 1ns/1ps

module frontEnd (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          loadEn,
    input  logic [frontPkg::memAddrW-1:0] loadAddr,
    input  logic [31:0]                   loadData,
    input  logic                          block,
    input  logic                          redirect,
    input  logic [63:0]                   redirectPc,
    input  logic                          csrIllegal,
    output frontPkg::decodeOut            result
);
    import frontPkg::*;

    memReq               memPort;
    logic [31:0]         rdata;
    logic                fetchGnt;
    logic                fetchRd;
    logic [memAddrW-1:0] fetchAddr;
    logic                issue;
    logic [63:0]         issuePc;
    logic                fault;

    instrMem u_mem (
        .clk   (clk),
        .req   (memPort),
        .rdata (rdata)
    );

    memArbiter u_arb (
        .clk       (clk),
        .arstN     (arstN),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .fetchRd   (fetchRd),
        .fetchAddr (fetchAddr),
        .fetchGnt  (fetchGnt),
        .memPort   (memPort)
    );

    fetchUnit u_fetch (
        .clk        (clk),
        .arstN      (arstN),
        .block      (block),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .gnt        (fetchGnt),
        .rdReq      (fetchRd),
        .rdAddr     (fetchAddr),
        .issue      (issue),
        .issuePc    (issuePc),
        .fault      (fault)
    );

    decodeStage u_decode (
        .clk        (clk),
        .arstN      (arstN),
        .block      (block),
        .issue      (issue),
        .issuePc    (issuePc),
        .fault      (fault),
        .instr      (rdata),
        .csrIllegal (csrIllegal),
        .result     (result)
    );

endmodule

// ==== tb/refDecode.svh ====
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

// expected decode of one word, per RV64I+M field rules
function automatic decodeOut refDecode(input logic [31:0] w, input logic csrBad);
    decodeOut   e;
    logic [4:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       md;
    logic       bad;
    e  = '0;
    op = w[6:2];
    f3 = w[14:12];
    f7 = w[31:25];
    md = (op == opOp || op == opOp32) && f7 == 7'd1;
    bad = 1'b0;
    e.imm = {{20{w[31]}}, w[31:20]}; // I format unless overridden
    e.ctrl.regWr = !(op == opBranch || op == opStore);
    e.ctrl.memRd = op == opLoad;
    e.ctrl.memWr = op == opStore;
    e.ctrl.memOp = f3;
    e.ctrl.aluASrc = op == opAuipc || op == opJal || op == opJalr;
    e.ctrl.aluBSrc = 2'd2;
    e.ctrl.aluCtl = aluAdd;
    e.ctrl.word32 = op == opOpImm32 || op == opOp32;
    e.ctrl.branch = brNone;
    e.ctrl.csr = op == opSystem;
    e.ctrl.isMul = md && f3 < 3'd4;
    e.ctrl.isDiv = md && f3 >= 3'd4;
    e.ctrl.isAlu = !md;
    if (op == opSystem) begin
        e.ctrl.aluBSrc = 2'd3;
        e.ctrl.aluCtl = aluPassB;
        bad = f3 == 3'd4;
    end else if (op == opLui || op == opAuipc) begin
        e.imm = {w[31:12], 12'b0};
        if (op == opLui) e.ctrl.aluCtl = aluPassB;
    end else if (op == opJal) begin
        e.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e.ctrl.aluBSrc = 2'd1;
        e.ctrl.branch = brJal;
    end else if (op == opJalr) begin
        e.ctrl.aluBSrc = 2'd1;
        e.ctrl.branch = brJalr;
        bad = f3 != 3'd0;
    end else if (op == opBranch) begin
        e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        e.ctrl.aluBSrc = 2'd0;
        e.ctrl.aluCtl = (f3 == 3'd6 || f3 == 3'd7) ? aluSltu : aluSlt;
        e.ctrl.branch = f3 == 3'd0 ? brEq : f3 == 3'd1 ? brNe :
                        (f3 == 3'd4 || f3 == 3'd6) ? brLt : (f3 >= 3'd5) ? brGe : brNone;
        bad = f3 == 3'd2 || f3 == 3'd3;
    end else if (op == opLoad) begin
        bad = f3 == 3'd7;
    end else if (op == opStore) begin
        e.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        bad = f3 > 3'd3;
    end else if (op == opOpImm || op == opOpImm32) begin
        e.ctrl.aluCtl = aluOp'({f7[5] && f3 == 3'd5, f3});
        if (op == opOpImm) begin
            bad = (f3 == 3'd1 && f7[6:1] != 6'd0) ||
                  (f3 == 3'd5 && f7[6:1] != 6'd0 && f7[6:1] != 6'd16);
        end else begin
            bad = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'd0) ||
                    (f3 == 3'd5 && (f7 == 7'd0 || f7 == 7'd32)));
        end
    end else if (op == opOp || op == opOp32) begin
        e.ctrl.aluBSrc = 2'd0;
        e.ctrl.aluCtl = aluOp'({f7[5], f3});
        if (f7 == 7'd32) bad = !(f3 == 3'd0 || f3 == 3'd5);
        else if (f7 == 7'd1) bad = op == opOp32 && f3 >= 3'd1 && f3 <= 3'd3;
        else if (f7 == 7'd0) bad = op == opOp32 && !(f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5);
        else bad = 1'b1;
    end else begin
        e.ctrl.aluBSrc = 2'd0; // unknown major opcode
        bad = 1'b1;
    end
    e.rd = w[11:7];
    e.csrAddr = w[31:20];
    e.ecall = w == 32'h0000_0073;
    e.done = w == 32'h0010_0073;
    e.mret = w == 32'h3020_0073;
    e.error = bad || w[1:0] != 2'b11 ||
              (op == opSystem && f3 == 3'd0 && !(e.ecall || e.done || e.mret)) ||
              (op == opSystem && f3 != 3'd0 && csrBad);
    return e;
endfunction

// random word over all major groups, system words and raw garbage
function automatic logic [31:0] buildWord(input logic [31:0] r, input logic [3:0] sel);
    logic [4:0] majors [12];
    majors = '{5'b00000, 5'b00100, 5'b00101, 5'b00110, 5'b01000, 5'b01100,
               5'b01101, 5'b01110, 5'b11000, 5'b11001, 5'b11011, 5'b11100};
    if (sel < 4'd12) return {r[31:7], majors[sel], 2'b11};
    if (sel == 4'd12) return 32'h0000_0073;
    if (sel == 4'd13) return 32'h0010_0073;
    if (sel == 4'd14) return 32'h3020_0073;
    return r; // mostly illegal
endfunction

function automatic logic [31:0] buildCsrrw(input logic [11:0] csr, input logic [4:0] rd);
    return {csr, 5'd3, 3'b001, rd, 7'b1110011};
endfunction

`endif

// ==== tb/frontEndTb.sv ====
`timescale 1ns/1ps

module frontEndTb;
    import frontPkg::*;

    `include "refDecode.svh"

    localparam int testCycles = 400;

    typedef logic [$bits(decodeOut)-1:0] wideVal;

    logic                clk;
    logic                arstN;
    logic                loadEn;
    logic [memAddrW-1:0] loadAddr;
    logic [31:0]         loadData;
    logic                block;
    logic                redirect;
    logic [63:0]         redirectPc;
    logic                csrIllegal;
    decodeOut            result;

    logic [31:0] shadow [memWords];
    logic [31:0] seed = 32'hb739_975a;
    logic [63:0] expQ [$];
    logic [63:0] modelPc;
    logic        runningM;
    logic        prevBlock;
    decodeOut    held;

    frontEnd u_frontEnd (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic stopRun();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic failWith(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stopRun();
    endtask

    task automatic mismatch(input string name, input wideVal exp, input wideVal act);
        $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
        stopRun();
    endtask

    task automatic checkResult(input logic [63:0] expPc);
        decodeOut e;
        assert (result.pc == expPc)
            else mismatch("result.pc", wideVal'(expPc), wideVal'(result.pc));
        if (expPc >= 64'(memWords * 4)) begin // access fault
            assert (result.error)
                else mismatch("result.error", wideVal'(1'b1), wideVal'(result.error));
        end else begin
            e = refDecode(shadow[expPc[memAddrW+1:2]], csrIllegal);
            assert (result.ctrl == e.ctrl)
                else mismatch("result.ctrl", wideVal'(e.ctrl), wideVal'(result.ctrl));
            assert (result.imm == e.imm)
                else mismatch("result.imm", wideVal'(e.imm), wideVal'(result.imm));
            assert (result.rd == e.rd)
                else mismatch("result.rd", wideVal'(e.rd), wideVal'(result.rd));
            assert (result.csrAddr == e.csrAddr)
                else mismatch("result.csrAddr", wideVal'(e.csrAddr), wideVal'(result.csrAddr));
            assert (result.ecall == e.ecall)
                else mismatch("result.ecall", wideVal'(e.ecall), wideVal'(result.ecall));
            assert (result.mret == e.mret)
                else mismatch("result.mret", wideVal'(e.mret), wideVal'(result.mret));
            assert (result.done == e.done)
                else mismatch("result.done", wideVal'(e.done), wideVal'(result.done));
            assert (result.error == e.error)
                else mismatch("result.error", wideVal'(e.error), wideVal'(result.error));
        end
    endtask

    // checks outputs of the ending cycle, then advances the pc model
    always @(posedge clk) begin
        if (!arstN) begin
            assert (!result.valid)
                else mismatch("result.valid", '0, wideVal'(result.valid));
            runningM = 1'b0;
            prevBlock = 1'b0;
        end else begin
            if (prevBlock) begin
                assert (result == held)
                    else mismatch("result", wideVal'(held), wideVal'(result));
            end else if (result.valid) begin
                if (expQ.size() == 0) failWith("valid output without a fetch issue");
                else checkResult(expQ.pop_front());
            end
            held = result;
            prevBlock = block;
            if (runningM && !block && !redirect && !loadEn) begin
                expQ.push_back(modelPc);
                if (modelPc < 64'(memWords * 4)) modelPc = modelPc + 64'd4;
            end
            if (redirect) modelPc = redirectPc;
            runningM = 1'b1;
        end
    end

    task automatic tick(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic loadWord(input int addr, input logic [31:0] data);
        loadEn = 1'b1;
        loadAddr = addr[memAddrW-1:0];
        loadData = data;
        shadow[addr] = data;
        tick(1);
        loadEn = 1'b0;
    endtask

    task automatic jumpTo(input logic [63:0] pc);
        redirect = 1'b1;
        redirectPc = pc;
        tick(1);
        redirect = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        arstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        block = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        csrIllegal = 1'b0;
        modelPc = resetPc;
        tick(16);
        arstN = 1'b1;
        for (int i = 0; i < memWords; i++) begin
            r = xorshift();
            loadWord(i, i == 20 ? buildCsrrw(12'h300, 5'd7) : buildWord(r, 4'(xorshift())));
        end
        tick(20);
        block = 1'b1;
        tick(6);
        block = 1'b0;
        tick(4);
        for (int i = 30; i < 36; i++) begin
            loadWord(i, shadow[i]); // same data, only steals memory cycles
            tick(2);
        end
        jumpTo(64'h40);
        tick(10);
        jumpTo(64'h400); // beyond the memory
        tick(5);
        csrIllegal = 1'b1;
        jumpTo(64'd80);
        tick(3);
        csrIllegal = 1'b0;
        jumpTo(64'd80);
        tick(50);
        if (expQ.size() > 1) begin
            failWith("issued fetches never reached the output");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

    initial begin
        #(testCycles * 100 + 2000);
        failWith("watchdog timeout");
    end

endmodule

// ==== project.f ====
+incdir+tb
rtl/frontPkg.sv
rtl/instrMem.sv
rtl/memArbiter.sv
rtl/fetchUnit.sv
rtl/instrDecoder.sv
rtl/immGen.sv
rtl/decodeStage.sv
rtl/frontEnd.sv
tb/frontEndTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module frontEndTb -f project.f -o simv

out=$(./obj_dir/simv || true)
echo "$out"

if grep -qxF ">>> PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi
